// File: common/iq_pkg.sv
package iq_pkg;

    // queue geometry
    localparam int NUM_ENTRIES = 16;
    localparam int ENTRY_IDX_W = $clog2(NUM_ENTRIES);

    // three functional units, memory is the fourth forward source
    localparam int NUM_UNITS = 3;
    localparam int UNIT_W    = 2;
    localparam int NUM_FWD   = 4;

    // physical register file
    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = $clog2(NUM_PREGS);

    localparam int XLEN      = 32;
    localparam int ROB_IDX_W = 6;

    // opcodes without an rs2 operand
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [XLEN-1:0]   word_t;

    // 139 bits, funct3 sits at the top and the unit number at the bottom
    typedef struct packed {
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [6:0]           opcode;
        preg_t                rd;
        preg_t                rs1;
        word_t                rs1_val;
        preg_t                rs2;
        word_t                rs2_val;
        word_t                imm;
        logic [ROB_IDX_W-1:0] rob_index;
        logic [UNIT_W-1:0]    unit;
    } iq_entry_t;

endpackage

// File: common/wakeup_if.sv
`timescale 1ns/1ps

// result forward bus, one slot per unit plus memory
interface wakeup_if;
    import iq_pkg::*;

    // one-cycle strobe, tag value final in that cycle
    logic [NUM_FWD-1:0] fwd_valid;
    preg_t              fwd_tag [NUM_FWD];
    word_t              fwd_val [NUM_FWD];

    modport source (
        output fwd_valid,
        output fwd_tag,
        output fwd_val
    );

    modport listener (
        input fwd_valid,
        input fwd_tag,
        input fwd_val
    );

endinterface

// File: issue_queue/reg_scoreboard.sv
`timescale 1ns/1ps

module reg_scoreboard (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          dispatch_en,
    input  iq_pkg::preg_t dispatch_rd,
    input  iq_pkg::preg_t rs1,
    input  iq_pkg::preg_t rs2,
    wakeup_if.listener    fwd,
    output logic          rs1_ready,
    output logic          rs2_ready
);
    import iq_pkg::*;

    // bit set once the value is available
    logic [NUM_PREGS-1:0] preg_ready;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            preg_ready <= '1;
        end else begin
            for (int s = 0; s < NUM_FWD; s++) begin
                if (fwd.fwd_valid[s]) begin
                    preg_ready[fwd.fwd_tag[s]] <= 1'b1;
                end
            end
            // new producer overrides a forward of the same tag
            if (dispatch_en) begin
                preg_ready[dispatch_rd] <= 1'b0;
            end
        end
    end

    // pre-edge state only since the entry array adds the bypass
    assign rs1_ready = preg_ready[rs1];
    assign rs2_ready = preg_ready[rs2];

endmodule

// File: issue_queue/iq_entry_array.sv
`timescale 1ns/1ps

module iq_entry_array (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           dispatch_valid,
    input  iq_pkg::iq_entry_t              dispatch_op,
    input  logic                           rs1_ready,
    input  logic                           rs2_ready,
    input  logic [iq_pkg::NUM_ENTRIES-1:0] grant,
    wakeup_if.listener                     fwd,
    output logic                           dispatch_en,
    output logic                           full,
    output iq_pkg::iq_entry_t              entries [iq_pkg::NUM_ENTRIES],
    output logic [iq_pkg::NUM_ENTRIES-1:0] ready
);
    import iq_pkg::*;

    logic [NUM_ENTRIES-1:0] use_bits;
    logic [NUM_ENTRIES-1:0] src1_rdy;
    logic [NUM_ENTRIES-1:0] src2_rdy;
    logic [ENTRY_IDX_W-1:0] free_idx;
    logic [UNIT_W-1:0]      rr_unit;

    // dispatch-cycle bypass
    logic      rs1_byp;
    logic      rs2_byp;
    word_t     rs1_byp_val;
    word_t     rs2_byp_val;
    logic      no_rs2;
    iq_entry_t new_entry;

    // wakeup hits of stored entries
    logic [NUM_ENTRIES-1:0] wake1;
    logic [NUM_ENTRIES-1:0] wake2;
    word_t                  wake1_val [NUM_ENTRIES];
    word_t                  wake2_val [NUM_ENTRIES];

    // lowest free slot, scanned from the top so index 0 wins
    always_comb begin
        free_idx = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!use_bits[i]) begin
                free_idx = ENTRY_IDX_W'(i);
            end
        end
    end

    assign full        = &use_bits;
    assign dispatch_en = dispatch_valid && !full;
    assign no_rs2      = (dispatch_op.opcode == OPC_OP_IMM) || (dispatch_op.opcode == OPC_LOAD);

    // tag match against the forward bus
    // sources walked downwards, so on a tie source 0 is kept
    always_comb begin
        rs1_byp     = 1'b0;
        rs2_byp     = 1'b0;
        rs1_byp_val = dispatch_op.rs1_val;
        rs2_byp_val = dispatch_op.rs2_val;
        wake1       = '0;
        wake2       = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wake1_val[i] = entries[i].rs1_val;
            wake2_val[i] = entries[i].rs2_val;
        end
        for (int s = NUM_FWD - 1; s >= 0; s--) begin
            if (fwd.fwd_valid[s]) begin
                if (fwd.fwd_tag[s] == dispatch_op.rs1) begin
                    rs1_byp     = 1'b1;
                    rs1_byp_val = fwd.fwd_val[s];
                end
                if (fwd.fwd_tag[s] == dispatch_op.rs2) begin
                    rs2_byp     = 1'b1;
                    rs2_byp_val = fwd.fwd_val[s];
                end
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (use_bits[i] && !src1_rdy[i] && entries[i].rs1 == fwd.fwd_tag[s]) begin
                        wake1[i]     = 1'b1;
                        wake1_val[i] = fwd.fwd_val[s];
                    end
                    if (use_bits[i] && !src2_rdy[i] && entries[i].rs2 == fwd.fwd_tag[s]) begin
                        wake2[i]     = 1'b1;
                        wake2_val[i] = fwd.fwd_val[s];
                    end
                end
            end
        end
    end

    always_comb begin
        new_entry         = dispatch_op;
        new_entry.unit    = rr_unit;
        new_entry.rs1_val = rs1_byp_val;
        new_entry.rs2_val = rs2_byp_val;
    end

    // control state
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            use_bits <= '0;
            src1_rdy <= '0;
            src2_rdy <= '0;
            rr_unit  <= '0;
        end else begin
            use_bits <= use_bits & ~grant;
            src1_rdy <= src1_rdy | wake1;
            src2_rdy <= src2_rdy | wake2;
            if (dispatch_en) begin
                use_bits[free_idx] <= 1'b1;
                src1_rdy[free_idx] <= rs1_ready || rs1_byp;
                src2_rdy[free_idx] <= rs2_ready || rs2_byp || no_rs2;
                rr_unit <= (rr_unit == UNIT_W'(NUM_UNITS - 1)) ? '0 : rr_unit + 1'b1;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (wake1[i]) begin
                entries[i].rs1_val <= wake1_val[i];
            end
            if (wake2[i]) begin
                entries[i].rs2_val <= wake2_val[i];
            end
        end
        if (dispatch_en) begin
            entries[free_idx] <= new_entry;
        end
    end

    assign ready = use_bits & src1_rdy & src2_rdy;

    a_dispatch_free: assert property (
        @(posedge clk) disable iff (!reset_n)
        dispatch_en |-> !use_bits[free_idx] && !grant[free_idx]
    ) else $error("dispatch into an occupied entry");

    // grants come from issue_select
    a_grant_used: assert property (
        @(posedge clk) disable iff (!reset_n)
        (grant & ~use_bits) == '0
    ) else $error("grant to an unused entry");

endmodule

// File: issue_queue/issue_select.sv
`timescale 1ns/1ps

module issue_select (
    input  logic                           clk,
    input  logic                           reset_n,
    input  iq_pkg::iq_entry_t              entries [iq_pkg::NUM_ENTRIES],
    input  logic [iq_pkg::NUM_ENTRIES-1:0] ready,
    output logic [iq_pkg::NUM_ENTRIES-1:0] grant,
    output logic [iq_pkg::NUM_UNITS-1:0]   issue_valid,
    output iq_pkg::iq_entry_t              issue_op [iq_pkg::NUM_UNITS]
);
    import iq_pkg::*;

    logic [NUM_ENTRIES-1:0] unit_grant [NUM_UNITS];
    logic [ENTRY_IDX_W-1:0] pick_idx [NUM_UNITS];
    logic [NUM_UNITS-1:0]   pick_valid;

    // per unit, lowest ready index whose unit field matches
    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            unit_grant[u] = '0;
            pick_idx[u]   = '0;
            pick_valid[u] = 1'b0;
            for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
                if (ready[i] && entries[i].unit == UNIT_W'(u)) begin
                    pick_idx[u]   = ENTRY_IDX_W'(i);
                    pick_valid[u] = 1'b1;
                end
            end
            if (pick_valid[u]) begin
                unit_grant[u][pick_idx[u]] = 1'b1;
            end
        end
    end

    // frees the picked entries at the issue edge
    always_comb begin
        grant = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            grant = grant | unit_grant[u];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= '0;
            for (int u = 0; u < NUM_UNITS; u++) begin
                issue_op[u] <= '0;
            end
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                issue_valid[u] <= pick_valid[u];
                issue_op[u]    <= pick_valid[u] ? entries[pick_idx[u]] : '0;
            end
        end
    end

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit_chk
        a_grant_onehot: assert property (
            @(posedge clk) disable iff (!reset_n)
            $onehot0(unit_grant[u])
        ) else $error("unit %0d granted more than one entry", u);

        // back-to-back issue needs a new grant behind the second pulse
        a_no_stale_issue: assert property (
            @(posedge clk) disable iff (!reset_n)
            (issue_valid[u] ##1 issue_valid[u]) |-> $past(|unit_grant[u])
        ) else $error("unit %0d held issue_valid without a grant", u);
    end

endmodule

// File: source/issue_queue_top.sv
`timescale 1ns/1ps

module issue_queue_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           dispatch_valid,
    input  logic [2:0]                     funct3,
    input  logic [6:0]                     funct7,
    input  logic [6:0]                     opcode,
    input  iq_pkg::preg_t                  rd,
    input  iq_pkg::preg_t                  rs1,
    input  iq_pkg::word_t                  rs1_val,
    input  iq_pkg::preg_t                  rs2,
    input  iq_pkg::word_t                  rs2_val,
    input  iq_pkg::word_t                  imm,
    input  logic [iq_pkg::ROB_IDX_W-1:0]   rob_index,
    input  logic [iq_pkg::NUM_FWD-1:0]     fwd_valid,
    input  iq_pkg::preg_t                  fwd_tag [iq_pkg::NUM_FWD],
    input  iq_pkg::word_t                  fwd_val [iq_pkg::NUM_FWD],
    output logic                           full,
    output logic [iq_pkg::NUM_UNITS-1:0]   issue_valid,
    output iq_pkg::iq_entry_t              issue_op [iq_pkg::NUM_UNITS]
);
    import iq_pkg::*;

    iq_entry_t              dispatch_op;
    logic                   dispatch_en;
    logic                   rs1_ready;
    logic                   rs2_ready;
    logic [NUM_ENTRIES-1:0] grant;
    logic [NUM_ENTRIES-1:0] ready;
    iq_entry_t              entries [NUM_ENTRIES];

    wakeup_if fwd_bus ();

    assign fwd_bus.fwd_valid = fwd_valid;
    assign fwd_bus.fwd_tag   = fwd_tag;
    assign fwd_bus.fwd_val   = fwd_val;

    // unit field is filled in by the array
    assign dispatch_op = '{funct3: funct3, funct7: funct7, opcode: opcode, rd: rd,
                           rs1: rs1, rs1_val: rs1_val, rs2: rs2, rs2_val: rs2_val,
                           imm: imm, rob_index: rob_index, unit: '0};

    reg_scoreboard u_scoreboard (
        .clk         (clk),
        .reset_n     (reset_n),
        .dispatch_en (dispatch_en),
        .dispatch_rd (rd),
        .rs1         (rs1),
        .rs2         (rs2),
        .fwd         (fwd_bus),
        .rs1_ready   (rs1_ready),
        .rs2_ready   (rs2_ready)
    );

    iq_entry_array u_entries (
        .clk            (clk),
        .reset_n        (reset_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .rs1_ready      (rs1_ready),
        .rs2_ready      (rs2_ready),
        .grant          (grant),
        .fwd            (fwd_bus),
        .dispatch_en    (dispatch_en),
        .full           (full),
        .entries        (entries),
        .ready          (ready)
    );

    issue_select u_select (
        .clk         (clk),
        .reset_n     (reset_n),
        .entries     (entries),
        .ready       (ready),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue_op    (issue_op)
    );

endmodule

// File: bench/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;
    import iq_pkg::*;

    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam int         TIMEOUT_CYC = 600;
    localparam int         OP_W        = $bits(iq_entry_t);

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 dispatch_valid;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [6:0]           opcode;
    preg_t                rd;
    preg_t                rs1;
    word_t                rs1_val;
    preg_t                rs2;
    word_t                rs2_val;
    word_t                imm;
    logic [ROB_IDX_W-1:0] rob_index;
    logic [NUM_FWD-1:0]   fwd_valid;
    preg_t                fwd_tag [NUM_FWD];
    word_t                fwd_val [NUM_FWD];
    logic                 full;
    logic [NUM_UNITS-1:0] issue_valid;
    iq_entry_t            issue_op [NUM_UNITS];

    // reference model state
    logic [NUM_PREGS-1:0]   sb_ready;
    logic [NUM_ENTRIES-1:0] m_use;
    logic [NUM_ENTRIES-1:0] m_r1;
    logic [NUM_ENTRIES-1:0] m_r2;
    iq_entry_t              m_ent [NUM_ENTRIES];
    int                     m_rr;
    iq_entry_t              exp_op [NUM_UNITS];
    logic [NUM_UNITS-1:0]   exp_valid;

    int    seed = 32'h229b551a;
    int    cycle_count = 0;
    int    check_count = 0;
    int    error_count = 0;
    int    test_count = 0;
    int    test_errors = 0;
    string test_name;
    preg_t tag;

    issue_queue_top u_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .dispatch_valid (dispatch_valid),
        .funct3         (funct3),
        .funct7         (funct7),
        .opcode         (opcode),
        .rd             (rd),
        .rs1            (rs1),
        .rs1_val        (rs1_val),
        .rs2            (rs2),
        .rs2_val        (rs2_val),
        .imm            (imm),
        .rob_index      (rob_index),
        .fwd_valid      (fwd_valid),
        .fwd_tag        (fwd_tag),
        .fwd_val        (fwd_val),
        .full           (full),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [OP_W-1:0] exp,
                         input logic [OP_W-1:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            test_errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic void reset_model();
        sb_ready = '1;
        m_use    = '0;
        m_r1     = '0;
        m_r2     = '0;
        m_rr     = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            m_ent[i] = '0;
        end
        for (int u = 0; u < NUM_UNITS; u++) begin
            exp_op[u] = '0;
        end
    endfunction

    // one rising edge of the queue and its expected issue_valid
    function automatic logic [NUM_UNITS-1:0] predict_issue();
        logic [NUM_UNITS-1:0]   valid;
        logic [NUM_ENTRIES-1:0] granted;
        logic                   accept;
        logic                   hit1;
        logic                   hit2;
        int                     pick;
        int                     free;
        iq_entry_t              e;
        valid   = '0;
        granted = '0;
        pick    = 0;
        free    = 0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            exp_op[u] = '0;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (!valid[u] && m_use[i] && m_r1[i] && m_r2[i] && m_ent[i].unit == u) begin
                    exp_op[u] = m_ent[i];
                    valid[u]  = 1'b1;
                    pick      = i;
                end
            end
            if (valid[u]) begin
                granted[pick] = 1'b1;
            end
        end
        accept = dispatch_valid && !(&m_use);
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!m_use[i]) begin
                free = i;
            end
        end
        // wakeup of waiting entries with the lowest source first
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            hit1 = 1'b0;
            hit2 = 1'b0;
            for (int s = 0; s < NUM_FWD; s++) begin
                if (fwd_valid[s] && m_use[i] && !m_r1[i] && !hit1 &&
                    fwd_tag[s] == m_ent[i].rs1) begin
                    m_ent[i].rs1_val = fwd_val[s];
                    hit1 = 1'b1;
                end
                if (fwd_valid[s] && m_use[i] && !m_r2[i] && !hit2 &&
                    fwd_tag[s] == m_ent[i].rs2) begin
                    m_ent[i].rs2_val = fwd_val[s];
                    hit2 = 1'b1;
                end
            end
            m_r1[i] = m_r1[i] | hit1;
            m_r2[i] = m_r2[i] | hit2;
        end
        if (accept) begin
            e = '{funct3: funct3, funct7: funct7, opcode: opcode, rd: rd, rs1: rs1,
                  rs1_val: rs1_val, rs2: rs2, rs2_val: rs2_val, imm: imm,
                  rob_index: rob_index, unit: UNIT_W'(m_rr)};
            hit1 = sb_ready[rs1];
            hit2 = sb_ready[rs2] || opcode == OPC_OP_IMM || opcode == OPC_LOAD;
            // walked downwards so source 0 is left on a tie
            for (int s = NUM_FWD - 1; s >= 0; s--) begin
                if (fwd_valid[s] && fwd_tag[s] == rs1) begin
                    e.rs1_val = fwd_val[s];
                    hit1 = 1'b1;
                end
                if (fwd_valid[s] && fwd_tag[s] == rs2) begin
                    e.rs2_val = fwd_val[s];
                    hit2 = 1'b1;
                end
            end
            m_ent[free] = e;
            m_use[free] = 1'b1;
            m_r1[free]  = hit1;
            m_r2[free]  = hit2;
            m_rr        = (m_rr + 1) % NUM_UNITS;
        end
        for (int s = 0; s < NUM_FWD; s++) begin
            if (fwd_valid[s]) begin
                sb_ready[fwd_tag[s]] = 1'b1;
            end
        end
        if (accept) begin
            sb_ready[rd] = 1'b0;
        end
        m_use = m_use & ~granted;
        return valid;
    endfunction

    // model steps on the edge and DUT outputs are read just after it
    initial begin
        forever begin
            @(posedge clk);
            if (!reset_n) begin
                reset_model();
                exp_valid = '0;
            end else begin
                exp_valid = predict_issue();
            end
            #1;
            check({test_name, " issue_valid"}, exp_valid, issue_valid);
            check({test_name, " full"}, &m_use, full);
            for (int u = 0; u < NUM_UNITS; u++) begin
                check($sformatf("%s issue_op[%0d]", test_name, u), exp_op[u], issue_op[u]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYC);
        $display("run stopped after %0d cycles before the tests finished", cycle_count);
        $display("TEST FAIL");
        $finish;
    end

    task automatic next_cycle();
        @(negedge clk);
        dispatch_valid = 1'b0;
        fwd_valid      = '0;
    endtask

    task automatic run_idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic set_dispatch(input logic [6:0] opc, input preg_t d, input preg_t s1,
                                input preg_t s2);
        dispatch_valid = 1'b1;
        opcode         = opc;
        rd             = d;
        rs1            = s1;
        rs2            = s2;
        funct3         = 3'($random(seed));
        funct7         = 7'($random(seed));
        rs1_val        = $random(seed);
        rs2_val        = $random(seed);
        imm            = $random(seed);
        rob_index      = ROB_IDX_W'($random(seed));
    endtask

    task automatic set_forward(input int src, input preg_t t);
        fwd_valid[src] = 1'b1;
        fwd_tag[src]   = t;
        fwd_val[src]   = $random(seed);
    endtask

    function automatic int random_source();
        return $unsigned($random(seed)) % NUM_FWD;
    endfunction

    // rd tags from the upper half that no test reads as a source
    function automatic preg_t random_far_tag();
        return preg_t'(32 + $unsigned($random(seed)) % 32);
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_count++;
    endtask

    task automatic finish_test();
        $display("%s: %0d errors", test_name, test_errors);
    endtask

    initial begin
        reset_n        = 1'b0;
        dispatch_valid = 1'b0;
        funct3         = '0;
        funct7         = '0;
        opcode         = '0;
        rd             = '0;
        rs1            = '0;
        rs1_val        = '0;
        rs2            = '0;
        rs2_val        = '0;
        imm            = '0;
        rob_index      = '0;
        fwd_valid      = '0;
        for (int s = 0; s < NUM_FWD; s++) begin
            fwd_tag[s] = '0;
            fwd_val[s] = '0;
        end
        start_test("reset and round robin");
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        for (int k = 0; k < 3; k++) begin
            set_dispatch(OPC_OP, random_far_tag(), 1, 2);
            next_cycle();
        end
        run_idle(3);
        finish_test();

        start_test("wakeup by forward");
        tag = preg_t'(16 + $unsigned($random(seed)) % 16);
        set_dispatch(OPC_OP, tag, 1, 2);
        next_cycle();
        set_dispatch(OPC_OP, random_far_tag(), tag, 2);
        next_cycle();
        set_dispatch(OPC_OP, random_far_tag(), 3, tag);
        next_cycle();
        run_idle(2);
        set_forward(random_source(), tag);
        next_cycle();
        run_idle(3);
        finish_test();

        start_test("rs2 ignored for imm and load");
        set_dispatch(OPC_OP, 11, 1, 2);
        next_cycle();
        set_dispatch(OPC_OP_IMM, random_far_tag(), 1, 11);
        next_cycle();
        set_dispatch(OPC_LOAD, random_far_tag(), 2, 11);
        next_cycle();
        set_dispatch(OPC_OP, random_far_tag(), 3, 11);
        next_cycle();
        run_idle(3);
        set_forward(random_source(), 11);
        next_cycle();
        run_idle(3);
        finish_test();

        start_test("dispatch cycle bypass");
        set_dispatch(OPC_OP, 12, 1, 2);
        next_cycle();
        run_idle(1);
        set_dispatch(OPC_OP, random_far_tag(), 12, 1);
        set_forward(random_source(), 12);
        next_cycle();
        run_idle(3);
        finish_test();

        start_test("full and drain");
        set_dispatch(OPC_OP, 13, 1, 2);
        next_cycle();
        run_idle(1);
        // the seventeenth one hits a full queue
        for (int k = 0; k < NUM_ENTRIES + 1; k++) begin
            set_dispatch(OPC_OP, random_far_tag(), 13, 1);
            next_cycle();
        end
        run_idle(2);
        set_forward(random_source(), 13);
        next_cycle();
        run_idle(10);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
common/iq_pkg.sv
common/wakeup_if.sv
issue_queue/reg_scoreboard.sv
issue_queue/iq_entry_array.sv
issue_queue/issue_select.sv
source/issue_queue_top.sv
bench/tb_issue_queue.sv
